// File: source/attn_proj_params.svh
// Shared widths and constants for the attention projection engine
`ifndef ATTN_PROJ_PARAMS_SVH
`define ATTN_PROJ_PARAMS_SVH

// SRAM word and address widths
`define ATTN_DATA_W 32
`define ATTN_ADDR_W 16

// One header dimension field, rows in the upper half and columns in the lower
`define ATTN_DIM_W 16

// Header word location in the input and weight SRAMs
`define ATTN_HDR_ADDR 0

// Weight matrices Q, K and V
`define ATTN_NUM_PROJ 3

`endif

// File: source/attn_proj_pkg.sv
// Shared struct and enum types of the attention projection engine
`include "attn_proj_params.svh"

package attn_proj_pkg;

  // Same layout as the header word
  typedef struct packed {
    logic [`ATTN_DIM_W-1:0] rows;
    logic [`ATTN_DIM_W-1:0] cols;
  } matrix_dims_t;

  typedef struct packed {
    logic [`ATTN_ADDR_W-1:0] addr;
  } sram_rd_t;

  typedef struct packed {
    logic                    en;
    logic [`ATTN_ADDR_W-1:0] addr;
    logic [`ATTN_DATA_W-1:0] data;
  } sram_wr_t;

  // Per-cycle operand control from the sequencer
  typedef struct packed {
    logic advance;
    logic dot_first;
    logic dot_last;
    logic row_last;
    logic proj_last;
  } operand_step_t;

  typedef enum logic [1:0] {
    IDLE,
    HEADER,
    COMPUTE,
    DONE
  } seq_state_e;

endpackage

// File: source/proj_sequencer.sv
// Projection sequencer with start handshake, header capture and operand step control
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module proj_sequencer
  import attn_proj_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   dut_valid,
  output logic                   dut_ready,
  input  matrix_dims_t           input_hdr,
  input  matrix_dims_t           weight_hdr,
  output logic                   hdr_phase,
  output matrix_dims_t           dims,
  output logic [`ATTN_DIM_W-1:0] out_cols,
  output operand_step_t          step,
  input  logic                   write_done
);

  localparam int PROJ_W = $clog2(`ATTN_NUM_PROJ);

  seq_state_e             state;
  seq_state_e             state_next;
  logic                   hdr_cnt;
  logic [`ATTN_DIM_W-1:0] k_cnt;
  logic [`ATTN_DIM_W-1:0] col_cnt;
  logic [`ATTN_DIM_W-1:0] row_cnt;
  logic [PROJ_W-1:0]      proj_cnt;
  logic                   last_proj;

  assign hdr_phase = (state == HEADER);
  assign last_proj = (proj_cnt == PROJ_W'(`ATTN_NUM_PROJ - 1));

  // One operand pair per compute cycle
  always_comb begin
    step.advance   = (state == COMPUTE);
    step.dot_first = step.advance && (k_cnt == '0);
    step.dot_last  = step.advance && (k_cnt == dims.cols - 1'b1);
    step.row_last  = step.dot_last && (col_cnt == out_cols - 1'b1);
    step.proj_last = step.row_last && (row_cnt == dims.rows - 1'b1);
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (dut_valid && dut_ready) state_next = HEADER;
      HEADER:  if (hdr_cnt) state_next = COMPUTE;
      COMPUTE: if (step.proj_last && last_proj) state_next = DONE;
      DONE:    if (write_done) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= IDLE;
      dut_ready <= 1'b0;
      hdr_cnt   <= 1'b0;
      k_cnt     <= '0;
      col_cnt   <= '0;
      row_cnt   <= '0;
      proj_cnt  <= '0;
    end else begin
      state     <= state_next;
      dut_ready <= (state_next == IDLE);
      // Cycle 0 issues the header address, cycle 1 sees its data
      hdr_cnt   <= hdr_phase && !hdr_cnt;
      if (step.advance) begin
        if (!step.dot_last) begin
          k_cnt <= k_cnt + 1'b1;
        end else begin
          k_cnt <= '0;
          if (!step.row_last) begin
            col_cnt <= col_cnt + 1'b1;
          end else begin
            col_cnt <= '0;
            if (!step.proj_last) begin
              row_cnt <= row_cnt + 1'b1;
            end else begin
              row_cnt  <= '0;
              proj_cnt <= last_proj ? '0 : proj_cnt + 1'b1;
            end
          end
        end
      end
    end
  end

  // K comes from the input header, M from the weight header
  always_ff @(posedge clk) begin
    if (hdr_phase && hdr_cnt) begin
      dims     <= input_hdr;
      out_cols <= weight_hdr.cols;
    end
  end

endmodule

// File: source/input_addr_gen.sv
// Input operand address generator, walks one input row per dot product
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module input_addr_gen
  import attn_proj_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  matrix_dims_t  dims,
  input  operand_step_t step,
  output sram_rd_t      rd
);

  // Elements follow the header word
  localparam logic [`ATTN_ADDR_W-1:0] FIRST_ADDR = `ATTN_ADDR_W'(`ATTN_HDR_ADDR + 1);

  logic [`ATTN_ADDR_W-1:0] row_base;
  logic [`ATTN_ADDR_W-1:0] cur_addr;
  logic [`ATTN_ADDR_W-1:0] next_row;

  assign next_row = row_base + `ATTN_ADDR_W'(dims.cols);
  assign rd       = '{addr: cur_addr};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      row_base <= FIRST_ADDR;
      cur_addr <= FIRST_ADDR;
    end else if (step.advance) begin
      if (step.proj_last) begin
        // Next projection starts again from row 0
        row_base <= FIRST_ADDR;
        cur_addr <= FIRST_ADDR;
      end else if (step.row_last) begin
        row_base <= next_row;
        cur_addr <= next_row;
      end else if (step.dot_last) begin
        // Same row again for the next output column
        cur_addr <= row_base;
      end else begin
        cur_addr <= cur_addr + 1'b1;
      end
    end
  end

endmodule

// File: source/weight_addr_gen.sv
// Weight operand address generator, walks the Q, K and V matrices column by column
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module weight_addr_gen
  import attn_proj_pkg::*;
(
  input  logic          clk,
  input  logic          reset_n,
  input  operand_step_t step,
  output sram_rd_t      rd
);

  localparam int PROJ_W = $clog2(`ATTN_NUM_PROJ);
  localparam logic [`ATTN_ADDR_W-1:0] FIRST_ADDR = `ATTN_ADDR_W'(`ATTN_HDR_ADDR + 1);

  logic [`ATTN_ADDR_W-1:0] mat_base;
  logic [`ATTN_ADDR_W-1:0] cur_addr;
  logic [PROJ_W-1:0]       proj_cnt;
  logic                    last_proj;

  assign last_proj = (proj_cnt == PROJ_W'(`ATTN_NUM_PROJ - 1));
  assign rd        = '{addr: cur_addr};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mat_base <= FIRST_ADDR;
      cur_addr <= FIRST_ADDR;
      proj_cnt <= '0;
    end else if (step.advance) begin
      if (step.proj_last) begin
        if (last_proj) begin
          mat_base <= FIRST_ADDR;
          cur_addr <= FIRST_ADDR;
          proj_cnt <= '0;
        end else begin
          // Matrices are packed back to back
          mat_base <= cur_addr + 1'b1;
          cur_addr <= cur_addr + 1'b1;
          proj_cnt <= proj_cnt + 1'b1;
        end
      end else if (step.row_last) begin
        // Next input row reuses the same columns
        cur_addr <= mat_base;
      end else begin
        cur_addr <= cur_addr + 1'b1;
      end
    end
  end

endmodule

// File: source/dot_product_mac.sv
// Dot-product MAC, accumulates fetched operand pairs and writes each sum to the result SRAM
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module dot_product_mac
  import attn_proj_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  operand_step_t           step,
  input  logic [`ATTN_DATA_W-1:0] input_data,
  input  logic [`ATTN_DATA_W-1:0] weight_data,
  output sram_wr_t                result_wr,
  output logic                    write_done
);

  localparam int PROJ_W = $clog2(`ATTN_NUM_PROJ);

  operand_step_t           step_q;
  logic [`ATTN_DATA_W-1:0] product;
  logic [`ATTN_DATA_W-1:0] sum_next;
  logic [`ATTN_DATA_W-1:0] acc;
  logic [`ATTN_ADDR_W-1:0] wr_cnt;
  logic [PROJ_W-1:0]       proj_cnt;
  logic                    wr_en;
  logic [`ATTN_ADDR_W-1:0] wr_addr;
  logic [`ATTN_DATA_W-1:0] wr_data;

  // Wraps to 32 bits
  assign product  = input_data * weight_data;
  assign sum_next = (step_q.dot_first ? '0 : acc) + product;

  // Final write of the run is being registered
  assign write_done = step_q.proj_last && (proj_cnt == PROJ_W'(`ATTN_NUM_PROJ - 1));

  assign result_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

  // Step delayed to meet the read data
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      step_q   <= '0;
      wr_en    <= 1'b0;
      wr_cnt   <= '0;
      proj_cnt <= '0;
    end else begin
      step_q <= step;
      wr_en  <= step_q.dot_last;
      if (step_q.dot_last) begin
        // Next run writes from address 0
        wr_cnt <= write_done ? '0 : wr_cnt + 1'b1;
      end
      if (step_q.proj_last) begin
        proj_cnt <= write_done ? '0 : proj_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step_q.advance) begin
      acc <= sum_next;
    end
    if (step_q.dot_last) begin
      wr_addr <= wr_cnt;
      wr_data <= sum_next;
    end
  end

endmodule

// File: source/attn_proj_top.sv
// Attention projection top, computes Q, K and V from SRAM-resident input and weights
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module attn_proj_top
  import attn_proj_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    dut_valid,
  output logic                    dut_ready,
  output sram_rd_t                input_rd,
  input  logic [`ATTN_DATA_W-1:0] input_rd_data,
  output sram_rd_t                weight_rd,
  input  logic [`ATTN_DATA_W-1:0] weight_rd_data,
  output sram_wr_t                result_wr
);

  localparam sram_rd_t HDR_RD = '{addr: `ATTN_ADDR_W'(`ATTN_HDR_ADDR)};

  matrix_dims_t  dims;
  operand_step_t step;
  logic          hdr_phase;
  logic          write_done;
  sram_rd_t      input_gen_rd;
  sram_rd_t      weight_gen_rd;

  // Both headers sit at the same address
  assign input_rd  = hdr_phase ? HDR_RD : input_gen_rd;
  assign weight_rd = hdr_phase ? HDR_RD : weight_gen_rd;

  // M only sets the column boundary inside the sequencer
  proj_sequencer proj_sequencer_inst (
    .clk        (clk),
    .reset_n    (reset_n),
    .dut_valid  (dut_valid),
    .dut_ready  (dut_ready),
    .input_hdr  (matrix_dims_t'(input_rd_data)),
    .weight_hdr (matrix_dims_t'(weight_rd_data)),
    .hdr_phase  (hdr_phase),
    .dims       (dims),
    .out_cols   (),
    .step       (step),
    .write_done (write_done)
  );

  input_addr_gen input_addr_gen_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .dims    (dims),
    .step    (step),
    .rd      (input_gen_rd)
  );

  weight_addr_gen weight_addr_gen_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .step    (step),
    .rd      (weight_gen_rd)
  );

  dot_product_mac dot_product_mac_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .step        (step),
    .input_data  (input_rd_data),
    .weight_data (weight_rd_data),
    .result_wr   (result_wr),
    .write_done  (write_done)
  );

endmodule

// File: test/tb_attn_proj.sv
// Testbench for the attention projection engine with SRAM models and directed tests
`timescale 1ns/100ps
`include "attn_proj_params.svh"

module tb_attn_proj
  import attn_proj_pkg::*;
();

  localparam int          MEM_DEPTH      = 256;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] LFSR_SEED      = 32'hf399c86d;
  localparam logic [31:0] LFSR_TAPS      = 32'ha3000000;

  logic                    clk;
  logic                    reset_n;
  logic                    dut_valid;
  logic                    dut_ready;
  sram_rd_t                input_rd;
  logic [`ATTN_DATA_W-1:0] input_rd_data;
  sram_rd_t                weight_rd;
  logic [`ATTN_DATA_W-1:0] weight_rd_data;
  sram_wr_t                result_wr;

  logic [`ATTN_DATA_W-1:0] input_mem    [MEM_DEPTH];
  logic [`ATTN_DATA_W-1:0] weight_mem   [MEM_DEPTH];
  logic [`ATTN_DATA_W-1:0] result_mem   [MEM_DEPTH];
  logic [`ATTN_DATA_W-1:0] expected_mem [MEM_DEPTH];
  logic [`ATTN_ADDR_W-1:0] input_addr_q;
  logic [`ATTN_ADDR_W-1:0] weight_addr_q;

  logic [31:0] lfsr_state;
  int          cur_n;
  int          cur_k;
  int          cur_m;
  int          write_limit;
  int          write_count;
  int          stray_writes;
  int          check_count;
  int          error_count;
  bit          aborted;

  always #4 clk = ~clk;

  attn_proj_top attn_proj_top_inst (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .dut_ready      (dut_ready),
    .input_rd       (input_rd),
    .input_rd_data  (input_rd_data),
    .weight_rd      (weight_rd),
    .weight_rd_data (weight_rd_data),
    .result_wr      (result_wr)
  );

  // SRAM read port, address taken on the rising edge and data driven half a cycle later
  always @(posedge clk) begin
    input_addr_q  <= input_rd.addr;
    weight_addr_q <= weight_rd.addr;
  end

  always @(negedge clk) begin
    input_rd_data  <= input_mem[input_addr_q];
    weight_rd_data <= weight_mem[weight_addr_q];
  end

  // Result SRAM write port
  always @(negedge clk) begin
    if (reset_n && result_wr.en) begin
      if (result_wr.addr < MEM_DEPTH) result_mem[result_wr.addr] = result_wr.data;
      if (result_wr.addr >= write_limit) stray_writes++;
      write_count++;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  task automatic random_word(output logic [31:0] word);
    word = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word = {word[30:0], lfsr_state[0]};
    end
  endtask

  function automatic int in_index(input int row, input int kk);
    in_index = 1 + row * cur_k + kk;
  endfunction

  // Weights are stored column by column, Q then K then V
  function automatic int wt_index(input int p, input int kk, input int col);
    wt_index = 1 + p * cur_k * cur_m + col * cur_k + kk;
  endfunction

  task automatic check_value(input string msg, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
    end
  endtask

  task automatic report_timeout(input string msg);
    error_count++;
    aborted = 1'b1;
    $display("Timeout at %0t: %s", $time, msg);
  endtask

  task automatic fill_memories();
    for (int a = 0; a < MEM_DEPTH; a++) begin
      input_mem[a]  = 32'h1f00_0000 ^ (a * 32'h9e37_79b9);
      weight_mem[a] = 32'h2e00_0000 ^ (a * 32'h85eb_ca6b);
    end
  endtask

  task automatic set_sizes(input int n, input int k, input int m);
    cur_n         = n;
    cur_k         = k;
    cur_m         = m;
    input_mem[0]  = {16'(n), 16'(k)};
    weight_mem[0] = {16'(k), 16'(m)};
    write_limit   = `ATTN_NUM_PROJ * n * m;
  endtask

  task automatic load_random();
    logic [31:0] w;
    for (int r = 0; r < cur_n; r++) begin
      for (int kk = 0; kk < cur_k; kk++) begin
        random_word(w);
        input_mem[in_index(r, kk)] = w;
      end
    end
    for (int a = 1; a <= `ATTN_NUM_PROJ * cur_k * cur_m; a++) begin
      random_word(w);
      weight_mem[a] = w;
    end
  endtask

  task automatic compute_expected();
    logic [31:0] sum;
    for (int p = 0; p < `ATTN_NUM_PROJ; p++) begin
      for (int r = 0; r < cur_n; r++) begin
        for (int c = 0; c < cur_m; c++) begin
          sum = '0;
          for (int kk = 0; kk < cur_k; kk++) begin
            sum += input_mem[in_index(r, kk)] * weight_mem[wt_index(p, kk, c)];
          end
          expected_mem[(p * cur_n + r) * cur_m + c] = sum;
        end
      end
    end
  endtask

  // Handshake, then wait for dut_ready to come back
  task automatic run_projection(input string tag);
    int cycles;
    for (int a = 0; a < MEM_DEPTH; a++) result_mem[a] = 'x;
    write_count  = 0;
    stray_writes = 0;
    cycles       = 0;
    while (dut_ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (dut_ready !== 1'b1) begin
      report_timeout({tag, ": dut_ready never rose before the start"});
    end else begin
      dut_valid = 1'b1;
      @(negedge clk);
      dut_valid = 1'b0;
      check_value({tag, ": dut_ready low after start"}, dut_ready, 1'b0);
      cycles = 0;
      while (dut_ready !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      if (dut_ready !== 1'b1) begin
        report_timeout({tag, ": run did not finish"});
      end else begin
        // Let the final write land
        @(negedge clk);
      end
    end
  endtask

  task automatic check_results(input string tag);
    for (int a = 0; a < write_limit; a++) begin
      check_value($sformatf("%s result at %0d", tag, a), result_mem[a], expected_mem[a]);
    end
    check_value({tag, ": write count"}, write_count, write_limit);
    check_value({tag, ": writes past the last result"}, stray_writes, 0);
  endtask

  task automatic test_idle_after_reset();
    repeat (20) begin
      @(negedge clk);
      check_value("idle dut_ready", dut_ready, 1'b1);
      check_value("idle result write enable", result_wr.en, 1'b0);
    end
    check_value("idle write count", write_count, 0);
  endtask

  task automatic test_identity_weights();
    logic [31:0] in_vals [4];
    logic [31:0] scale   [3];
    in_vals = '{32'd3, 32'd5, 32'd7, 32'd11};
    scale   = '{32'd1, 32'd2, 32'd0};
    set_sizes(2, 2, 2);
    for (int a = 0; a < 4; a++) input_mem[1 + a] = in_vals[a];
    for (int p = 0; p < 3; p++) begin
      for (int kk = 0; kk < 2; kk++) begin
        for (int c = 0; c < 2; c++) begin
          weight_mem[wt_index(p, kk, c)] = (kk == c) ? scale[p] : 32'd0;
        end
      end
    end
    run_projection("identity");
    if (!aborted) begin
      for (int a = 0; a < 12; a++) begin
        check_value($sformatf("identity result at %0d", a), result_mem[a],
                    scale[a / 4] * in_vals[a % 4]);
      end
      check_value("identity write count", write_count, 12);
    end
  endtask

  task automatic test_random_data();
    set_sizes(3, 4, 2);
    load_random();
    compute_expected();
    run_projection("random");
    if (!aborted) check_results("random");
  endtask

  // All-ones inputs, so each product is the negated weight modulo 2^32
  task automatic test_wraparound();
    logic [31:0] wt_vals [3];
    logic [31:0] sums    [3];
    wt_vals = '{32'hffff_ffff, 32'hffff_fffe, 32'h8000_0000};
    sums    = '{32'd3, 32'd6, 32'h8000_0000};
    set_sizes(2, 3, 2);
    for (int a = 1; a <= 6; a++) input_mem[a] = 32'hffff_ffff;
    for (int p = 0; p < 3; p++) begin
      for (int a = 0; a < 6; a++) weight_mem[1 + p * 6 + a] = wt_vals[p];
    end
    compute_expected();
    run_projection("wrap");
    if (!aborted) begin
      for (int a = 0; a < 12; a++) begin
        check_value($sformatf("wrap sum at %0d", a), result_mem[a], sums[a / 4]);
      end
      check_results("wrap");
    end
  endtask

  task automatic test_back_to_back();
    set_sizes(2, 3, 3);
    load_random();
    compute_expected();
    run_projection("first run");
    if (!aborted) begin
      check_results("first run");
      set_sizes(1, 2, 2);
      load_random();
      compute_expected();
      run_projection("second run");
      if (!aborted) check_results("second run");
    end
  endtask

  initial begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    dut_valid      = 1'b0;
    input_rd_data  = '0;
    weight_rd_data = '0;
    lfsr_state     = LFSR_SEED;
    write_limit    = 0;
    write_count    = 0;
    stray_writes   = 0;
    check_count    = 0;
    error_count    = 0;
    aborted        = 1'b0;
    fill_memories();
    repeat (4) @(negedge clk);
    reset_n = 1'b1;

    test_idle_after_reset();
    if (!aborted) test_identity_weights();
    if (!aborted) test_random_data();
    if (!aborted) test_wraparound();
    if (!aborted) test_back_to_back();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+source
source/attn_proj_pkg.sv
source/proj_sequencer.sv
source/input_addr_gen.sv
source/weight_addr_gen.sv
source/dot_product_mac.sv
source/attn_proj_top.sv
test/tb_attn_proj.sv

// File: Makefile
TOP := tb_attn_proj

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
